/* Bender.yml */
package:
  name: exec_slice

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/reg_file.sv
      - logic/forward_ctrl.sv
      - logic/operand_muxes.sv
      - logic/exec_unit.sv
      - logic/exec_slice.sv
  - target: test
    files:
      - test/exec_slice_sva.sv
      - test/exec_slice_tb.sv

/* logic/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath sizes
	//////////////////////////////////////////////////////////////////////

	// One machine word
	localparam int unsigned DATA_W = 32;

	// Register index width and register count
	localparam int unsigned REG_AW   = 5;
	localparam int unsigned NUM_REGS = 32;

	//////////////////////////////////////////////////////////////////////
	// Operand source selects
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned SEL_W = 2;

	// Plain register file read
	localparam logic [SEL_W-1:0] SEL_RF      = 2'd0;
	// Sign-extended immediate, operand B only
	localparam logic [SEL_W-1:0] SEL_IMM     = 2'd1;
	// Bypass from the ALU output in EX
	localparam logic [SEL_W-1:0] SEL_EX_FORW = 2'd2;
	// Bypass from the WB result register
	localparam logic [SEL_W-1:0] SEL_WB_FORW = 2'd3;

	//////////////////////////////////////////////////////////////////////
	// ALU operations
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned OP_W = 3;

	// Shifts take the low 5 bits of operand B
	typedef enum logic [OP_W-1:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6
	} alu_op_e;

endpackage

`default_nettype wire

/* logic/exec_slice.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_slice (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        id_freeze,
	input  logic                        ex_freeze,
	// Decoded instruction fields
	input  logic                        id_valid,
	input  exec_pkg::alu_op_e           id_op,
	input  logic [exec_pkg::REG_AW-1:0] id_rd,
	input  logic [exec_pkg::REG_AW-1:0] id_ra,
	input  logic [exec_pkg::REG_AW-1:0] id_rb,
	input  logic [exec_pkg::DATA_W-1:0] id_imm,
	input  logic                        id_use_imm,
	// Retirement
	output logic                        ret_valid,
	output logic [exec_pkg::REG_AW-1:0] ret_rd,
	output logic [exec_pkg::DATA_W-1:0] ret_data
);

	import exec_pkg::*;

	// Decode side
	logic [DATA_W-1:0] rf_data_a;
	logic [DATA_W-1:0] rf_data_b;
	logic [SEL_W-1:0]  sel_a;
	logic [SEL_W-1:0]  sel_b;
	logic [DATA_W-1:0] operand_a;
	logic [DATA_W-1:0] operand_b;
	// Stage state used for bypass
	logic              ex_valid;
	logic [REG_AW-1:0] ex_rd;
	logic [DATA_W-1:0] ex_forw;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_rd;
	logic [DATA_W-1:0] wb_forw;

	//////////////////////////////////////////////////////////////////////
	// Decode stage
	//////////////////////////////////////////////////////////////////////

	// Retirement writes back on the same edge it is reported
	reg_file reg_file_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_a (id_ra),
		.rdata_a (rf_data_a),
		.raddr_b (id_rb),
		.rdata_b (rf_data_b),
		.we      (ret_valid),
		.waddr   (wb_rd),
		.wdata   (wb_forw)
	);

	forward_ctrl forward_ctrl_inst (
		.ra       (id_ra),
		.rb       (id_rb),
		.use_imm  (id_use_imm),
		.ex_valid (ex_valid),
		.ex_rd    (ex_rd),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.sel_a    (sel_a),
		.sel_b    (sel_b)
	);

	operand_muxes operand_muxes_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (id_imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and writeback
	//////////////////////////////////////////////////////////////////////

	exec_unit exec_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_valid  (id_valid),
		.id_op     (id_op),
		.id_rd     (id_rd),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_valid  (ex_valid),
		.ex_rd     (ex_rd),
		.ex_forw   (ex_forw),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_forw   (wb_forw),
		.ret_valid (ret_valid)
	);

	// Retire fields come straight from WB
	assign ret_rd   = wb_rd;
	assign ret_data = wb_forw;

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        id_freeze,
	input  logic                        ex_freeze,
	// Decode control fields
	input  logic                        id_valid,
	input  exec_pkg::alu_op_e           id_op,
	input  logic [exec_pkg::REG_AW-1:0] id_rd,
	// Operands already registered into EX
	input  logic [exec_pkg::DATA_W-1:0] operand_a,
	input  logic [exec_pkg::DATA_W-1:0] operand_b,
	// EX stage state and bypass
	output logic                        ex_valid,
	output logic [exec_pkg::REG_AW-1:0] ex_rd,
	output logic [exec_pkg::DATA_W-1:0] ex_forw,
	// WB stage state and bypass
	output logic                        wb_valid,
	output logic [exec_pkg::REG_AW-1:0] wb_rd,
	output logic [exec_pkg::DATA_W-1:0] wb_forw,
	// Retire strobe, doubles as register file write enable
	output logic                        ret_valid
);

	import exec_pkg::*;

	// Operation held in EX
	alu_op_e ex_op;

	//////////////////////////////////////////////////////////////////////
	// EX control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_op    <= OP_ADD;
			ex_rd    <= '0;
		end else if (!ex_freeze) begin
			// Decode freeze alone turns the slot into a bubble
			ex_valid <= id_valid && !id_freeze;
			ex_op    <= id_op;
			ex_rd    <= id_rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	// Arithmetic wraps at 32 bits, shifts are logical
	always_comb begin
		case (ex_op)
			OP_ADD:  ex_forw = operand_a + operand_b;
			OP_SUB:  ex_forw = operand_a - operand_b;
			OP_AND:  ex_forw = operand_a & operand_b;
			OP_OR:   ex_forw = operand_a | operand_b;
			OP_XOR:  ex_forw = operand_a ^ operand_b;
			// Shift amount is the low 5 bits only
			OP_SLL:  ex_forw = operand_a << operand_b[4:0];
			OP_SRL:  ex_forw = operand_a >> operand_b[4:0];
			default: ex_forw = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// WB register
	//////////////////////////////////////////////////////////////////////

	// Control side, held while EX is frozen
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
		end
	end

	// Result word
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_forw <= ex_forw;
		end
	end

	// Frozen WB must not retire, or the write would repeat
	assign ret_valid = wb_valid && !ex_freeze;

endmodule

`default_nettype wire

/* logic/forward_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module forward_ctrl (
	// Decode source registers
	input  logic [exec_pkg::REG_AW-1:0] ra,
	input  logic [exec_pkg::REG_AW-1:0] rb,
	input  logic                        use_imm,
	// Destination of the instruction in EX
	input  logic                        ex_valid,
	input  logic [exec_pkg::REG_AW-1:0] ex_rd,
	// Destination of the instruction in WB
	input  logic                        wb_valid,
	input  logic [exec_pkg::REG_AW-1:0] wb_rd,
	// Source selects for the operand muxes
	output logic [exec_pkg::SEL_W-1:0]  sel_a,
	output logic [exec_pkg::SEL_W-1:0]  sel_b
);

	import exec_pkg::*;

	// Hazard hits per source and stage
	logic ex_hit_a;
	logic wb_hit_a;
	logic ex_hit_b;
	logic wb_hit_b;

	// Register 0 never forwards since it always reads zero
	assign ex_hit_a = ex_valid && (ex_rd != '0) && (ex_rd == ra);
	assign wb_hit_a = wb_valid && (wb_rd != '0) && (wb_rd == ra);
	assign ex_hit_b = ex_valid && (ex_rd != '0) && (ex_rd == rb);
	assign wb_hit_b = wb_valid && (wb_rd != '0) && (wb_rd == rb);

	// EX is the younger producer and wins over WB
	always_comb begin
		if (ex_hit_a) begin
			sel_a = SEL_EX_FORW;
		end else if (wb_hit_a) begin
			sel_a = SEL_WB_FORW;
		end else begin
			sel_a = SEL_RF;
		end
	end

	// Immediate overrides any hazard on rb
	always_comb begin
		if (use_imm) begin
			sel_b = SEL_IMM;
		end else if (ex_hit_b) begin
			sel_b = SEL_EX_FORW;
		end else if (wb_hit_b) begin
			sel_b = SEL_WB_FORW;
		end else begin
			sel_b = SEL_RF;
		end
	end

endmodule

`default_nettype wire

/* logic/operand_muxes.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_muxes (
	input  logic                        clk,
	input  logic                        rst_n,
	// Pipeline freezes from the stall controller
	input  logic                        id_freeze,
	input  logic                        ex_freeze,
	// Candidate sources
	input  logic [exec_pkg::DATA_W-1:0] rf_data_a,
	input  logic [exec_pkg::DATA_W-1:0] rf_data_b,
	input  logic [exec_pkg::DATA_W-1:0] ex_forw,
	input  logic [exec_pkg::DATA_W-1:0] wb_forw,
	input  logic [exec_pkg::DATA_W-1:0] simm,
	// Source selects from forwarding control
	input  logic [exec_pkg::SEL_W-1:0]  sel_a,
	input  logic [exec_pkg::SEL_W-1:0]  sel_b,
	// Registered operands into EX
	output logic [exec_pkg::DATA_W-1:0] operand_a,
	output logic [exec_pkg::DATA_W-1:0] operand_b
);

	import exec_pkg::*;

	// Mux outputs ahead of the EX registers
	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;
	// Set once an operand is captured under decode freeze
	logic              saved_a;
	logic              saved_b;

	//////////////////////////////////////////////////////////////////////
	// Source multiplexers
	//////////////////////////////////////////////////////////////////////

	// Operand A has no immediate path
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_data_a;
		endcase
	end

	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////////////////////////

	// Capture once while decode is frozen, then hold until full release
	// Keeps a bypassed value after its producer has retired
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_a <= '0;
			saved_a   <= 1'b0;
		end else if (!ex_freeze && !saved_a) begin
			operand_a <= muxed_a;
			saved_a   <= id_freeze;
		end else if (!ex_freeze && !id_freeze) begin
			// Release edge, captured value goes into EX unchanged
			saved_a <= 1'b0;
		end
	end

	// Same rule for operand B
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_b <= '0;
			saved_b   <= 1'b0;
		end else if (!ex_freeze && !saved_b) begin
			operand_b <= muxed_b;
			saved_b   <= id_freeze;
		end else if (!ex_freeze && !id_freeze) begin
			saved_b <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	// Read port A
	input  logic [exec_pkg::REG_AW-1:0] raddr_a,
	output logic [exec_pkg::DATA_W-1:0] rdata_a,
	// Read port B
	input  logic [exec_pkg::REG_AW-1:0] raddr_b,
	output logic [exec_pkg::DATA_W-1:0] rdata_b,
	// Single write port, driven by retirement
	input  logic                        we,
	input  logic [exec_pkg::REG_AW-1:0] waddr,
	input  logic [exec_pkg::DATA_W-1:0] wdata
);

	import exec_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Register 0 is hardwired, so only 1 to 31 are stored
	logic [DATA_W-1:0] regs [1:NUM_REGS-1];

	// Synchronous clear of every stored register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			// Writes aimed at register 0 are dropped
			regs[waddr] <= wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	// No write-through
	// A value written at an edge shows up here after that edge
	always_comb begin
		if (raddr_a == '0) begin
			rdata_a = '0;
		end else begin
			rdata_a = regs[raddr_a];
		end
		if (raddr_b == '0) begin
			rdata_b = '0;
		end else begin
			rdata_b = regs[raddr_b];
		end
	end

endmodule

`default_nettype wire

/* tb.f */
logic/exec_pkg.sv
logic/reg_file.sv
logic/forward_ctrl.sv
logic/operand_muxes.sv
logic/exec_unit.sv
logic/exec_slice.sv
test/exec_slice_sva.sv
test/exec_slice_tb.sv

/* test/exec_slice_golden.txt */
# C name id_freeze ex_freeze valid op rd ra rb imm_hex use_imm (op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl)
# R name rd data_hex, expected retirements in program order
# Registers read zero after reset
C rst 0 0 1 0 1 1 2 00000000 0
R rst 1 00000000
# Constants, then every ALU operation on settled registers
C alu_ld 0 0 1 0 2 0 0 12345678 1
R alu_ld 2 12345678
C alu_ld 0 0 1 0 3 0 0 fffffff0 1
R alu_ld 3 fffffff0
C alu_ld 0 0 1 0 4 0 0 00000024 1
R alu_ld 4 00000024
C alu_sub 0 0 1 1 5 1 2 00000000 0
R alu_sub 5 edcba988
C alu_and 0 0 1 2 6 2 3 00000000 0
R alu_and 6 12345670
C alu_or 0 0 1 3 7 3 0 0000000f 1
R alu_or 7 ffffffff
C alu_xor 0 0 1 4 8 2 0 0f0f0f0f 1
R alu_xor 8 1d3b5977
C alu_sll 0 0 1 5 9 2 4 00000000 0
R alu_sll 9 23456780
C alu_srl 0 0 1 6 10 3 0 00000044 1
R alu_srl 10 0fffffff
# Bypass from EX, from WB, from the register file, EX over WB
C fwd_ex 0 0 1 0 11 2 0 00000001 1
R fwd_ex 11 12345679
C fwd_ex 0 0 1 1 12 11 2 00000000 0
R fwd_ex 12 00000001
C fwd_wb 0 0 1 0 13 11 12 00000000 0
R fwd_wb 13 1234567a
C fwd_rf 0 0 1 4 14 11 13 00000000 0
R fwd_rf 14 00000003
C fwd_pri 0 0 1 0 14 0 0 00000005 1
R fwd_pri 14 00000005
C fwd_pri 0 0 1 0 15 14 14 00000000 0
R fwd_pri 15 0000000a
# Register 0 ignores writes and never forwards
C r0 0 0 1 0 0 2 0 00000000 1
R r0 0 12345678
C r0 0 0 1 3 16 0 0 00000000 0
R r0 16 00000000
C r0 0 0 1 0 17 0 0 00000007 1
R r0 17 00000007
# Decode freeze while the producer retires
C idf 0 0 1 0 18 2 0 00000100 1
R idf 18 12345778
C idf 1 0 1 0 19 18 18 00000000 0
C idf 1 0 1 0 19 18 18 00000000 0
C idf 0 0 1 0 19 18 18 00000000 0
R idf 19 2468aef0
C idf 0 0 1 0 20 19 18 00000000 0
R idf 20 369d0668
# Execute freeze holds EX and WB
C exf 0 0 1 0 21 20 0 00000001 1
R exf 21 369d0669
C exf 1 1 1 4 22 21 20 00000000 0
C exf 1 1 1 4 22 21 20 00000000 0
C exf 1 0 1 4 22 21 20 00000000 0
C exf 0 0 1 4 22 21 20 00000000 0
R exf 22 00000001

/* test/exec_slice_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_slice_sva (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        id_freeze,
	input logic                        ex_freeze,
	input logic [exec_pkg::SEL_W-1:0]  sel_a,
	input logic                        saved_a,
	input logic                        saved_b,
	input logic [exec_pkg::DATA_W-1:0] operand_a,
	input logic [exec_pkg::DATA_W-1:0] operand_b
);

	import exec_pkg::*;

	// Violation counters
	int unsigned freeze_errs = 0;
	int unsigned hold_a_errs = 0;
	int unsigned hold_b_errs = 0;
	int unsigned sel_errs    = 0;

	// Execute freeze always comes with a decode freeze
	freeze_order: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |-> id_freeze)
		else begin
			$error("ex_freeze is high while id_freeze is low");
			freeze_errs++;
		end

	// Saved operands hold until both freezes drop
	hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		(saved_a && (ex_freeze || id_freeze)) |=> $stable(operand_a))
		else begin
			$error("operand_a changed while saved");
			hold_a_errs++;
		end

	hold_b: assert property (@(posedge clk) disable iff (!rst_n)
		(saved_b && (ex_freeze || id_freeze)) |=> $stable(operand_b))
		else begin
			$error("operand_b changed while saved");
			hold_b_errs++;
		end

	// No immediate path on operand A
	sel_a_legal: assert property (@(posedge clk) disable iff (!rst_n)
		sel_a != SEL_IMM)
		else begin
			$error("sel_a selects the immediate");
			sel_errs++;
		end

endmodule

bind operand_muxes exec_slice_sva operand_checks (
	.clk       (clk),
	.rst_n     (rst_n),
	.id_freeze (id_freeze),
	.ex_freeze (ex_freeze),
	.sel_a     (sel_a),
	.saved_a   (saved_a),
	.saved_b   (saved_b),
	.operand_a (operand_a),
	.operand_b (operand_b)
);

`default_nettype wire

/* test/exec_slice_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_slice_tb;

	import exec_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 2;
	localparam int DRAIN_LIMIT  = 200;
	localparam int TAIL_CYCLES  = 4;
	localparam     GOLDEN_PATH  = "test/exec_slice_golden.txt";

	//////////////////////////////////////////////////////////////////////
	// DUT signals
	//////////////////////////////////////////////////////////////////////

	logic              clk = 1'b0;
	logic              rst_n;
	logic              id_freeze;
	logic              ex_freeze;
	logic              id_valid;
	alu_op_e           id_op;
	logic [REG_AW-1:0] id_rd;
	logic [REG_AW-1:0] id_ra;
	logic [REG_AW-1:0] id_rb;
	logic [DATA_W-1:0] id_imm;
	logic              id_use_imm;
	logic              ret_valid;
	logic [REG_AW-1:0] ret_rd;
	logic [DATA_W-1:0] ret_data;

	// One entry per C line of the golden file
	int                stim_idf [$];
	int                stim_exf [$];
	int                stim_vld [$];
	int                stim_op [$];
	int                stim_rd [$];
	int                stim_ra [$];
	int                stim_rb [$];
	logic [DATA_W-1:0] stim_imm [$];
	int                stim_use [$];

	// One entry per R line in retirement order
	logic [8*32-1:0]   exp_name [$];
	logic [REG_AW-1:0] exp_rd [$];
	logic [DATA_W-1:0] exp_data [$];

	// Run progress
	int                cur_cycle;
	int                first_valid;
	int                ret_idx;

	exec_slice exec_slice_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.id_valid   (id_valid),
		.id_op      (id_op),
		.id_rd      (id_rd),
		.id_ra      (id_ra),
		.id_rb      (id_rb),
		.id_imm     (id_imm),
		.id_use_imm (id_use_imm),
		.ret_valid  (ret_valid),
		.ret_rd     (ret_rd),
		.ret_data   (ret_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// Reads every C and R line and skips lines tagged #
	task automatic load_golden();
		int               fd;
		int               n;
		logic             done;
		logic [8*32-1:0]  tag;
		logic [8*32-1:0]  name;
		logic [8*128-1:0] rest;
		int               idf;
		int               exf;
		int               vld;
		int               op;
		int               rd;
		int               ra;
		int               rb;
		int               use_imm;
		logic [31:0]      word;
		fd = $fopen(GOLDEN_PATH, "r");
		assert (fd != 0) else fail_now("could not open the golden file");
		done = 1'b0;
		first_valid = -1;
		while (!done) begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				n = $fgets(rest, fd);
			end else if (tag == "C") begin
				n = $fscanf(fd, "%s %d %d %d %d %d %d %d %h %d",
					name, idf, exf, vld, op, rd, ra, rb, word, use_imm);
				assert (n == 10) else fail_now("a stimulus line of the golden file is malformed");
				if (first_valid < 0 && vld != 0) begin
					first_valid = stim_op.size();
				end
				stim_idf.push_back(idf);
				stim_exf.push_back(exf);
				stim_vld.push_back(vld);
				stim_op.push_back(op);
				stim_rd.push_back(rd);
				stim_ra.push_back(ra);
				stim_rb.push_back(rb);
				stim_imm.push_back(word);
				stim_use.push_back(use_imm);
			end else if (tag == "R") begin
				n = $fscanf(fd, "%s %d %h", name, rd, word);
				assert (n == 3) else fail_now("a retirement line of the golden file is malformed");
				exp_name.push_back(name);
				exp_rd.push_back(rd[REG_AW-1:0]);
				exp_data.push_back(word);
			end else begin
				fail_now($sformatf("unknown line tag %0s in the golden file", tag));
			end
		end
		$fclose(fd);
	endtask

	// Quiet decode with no freezes
	task automatic apply_idle();
		id_freeze  = 1'b0;
		ex_freeze  = 1'b0;
		id_valid   = 1'b0;
		id_op      = OP_ADD;
		id_rd      = '0;
		id_ra      = '0;
		id_rb      = '0;
		id_imm     = '0;
		id_use_imm = 1'b0;
	endtask

	task automatic apply_cycle(input int k);
		id_freeze  = (stim_idf[k] != 0);
		ex_freeze  = (stim_exf[k] != 0);
		id_valid   = (stim_vld[k] != 0);
		id_op      = alu_op_e'(stim_op[k]);
		id_rd      = stim_rd[k][REG_AW-1:0];
		id_ra      = stim_ra[k][REG_AW-1:0];
		id_rb      = stim_rb[k][REG_AW-1:0];
		id_imm     = stim_imm[k];
		id_use_imm = (stim_use[k] != 0);
	endtask

	task automatic check_retire(input int idx);
		assert (ret_rd === exp_rd[idx])
			else fail_now($sformatf("MISMATCH %0s rd expected %0d actual %0d",
				exp_name[idx], exp_rd[idx], ret_rd));
		assert (ret_data === exp_data[idx])
			else fail_now($sformatf("MISMATCH %0s data expected %08h actual %08h",
				exp_name[idx], exp_data[idx], ret_data));
	endtask

	// Counters kept by the bound operand checker
	function automatic int bound_violations();
		return exec_slice_inst.operand_muxes_inst.operand_checks.freeze_errs
			+ exec_slice_inst.operand_muxes_inst.operand_checks.hold_a_errs
			+ exec_slice_inst.operand_muxes_inst.operand_checks.hold_b_errs
			+ exec_slice_inst.operand_muxes_inst.operand_checks.sel_errs;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Retirement monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled mid-cycle with one retirement per high strobe
	always @(negedge clk) begin
		assert (bound_violations() == 0)
			else fail_now("a bound operand assertion fired during the run");
		if (rst_n !== 1'b1) begin
			assert (ret_valid === 1'b0) else fail_now("retire strobe is high during reset");
		end else begin
			assert (!$isunknown(ret_valid)) else fail_now("retire strobe is unknown after reset");
			if (ret_valid === 1'b1) begin
				// Earliest retirement is two cycles after the first issue
				assert (first_valid >= 0 && cur_cycle >= first_valid + 2)
					else fail_now("retirement seen before any instruction could reach WB");
				assert (ret_idx < exp_rd.size())
					else fail_now("retirement seen with no expected retirement left");
				check_retire(ret_idx);
				ret_idx++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int k;
		int waited;
		apply_idle();
		rst_n     = 1'b0;
		cur_cycle = -1;
		ret_idx   = 0;
		load_golden();
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		// One golden line per clock
		for (k = 0; k < stim_op.size(); k++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			apply_cycle(k);
			cur_cycle = k;
		end
		// Drain the pipeline
		waited = 0;
		while (ret_idx < exp_rd.size() && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			apply_idle();
			cur_cycle++;
			waited++;
		end
		// Extra cycles catch a stray retirement
		repeat (TAIL_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		assert (bound_violations() == 0)
			else fail_now("a bound operand assertion fired during the run");
		if (ret_idx == exp_rd.size()) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_now($sformatf("timeout after %0d cycles, %0d of %0d retirements seen",
				DRAIN_LIMIT, ret_idx, exp_rd.size()));
		end
	end

endmodule

`default_nettype wire
